/* logic/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Register format, opcode SPECIAL
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // Immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // Function field under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    //////////////////////////////////////////////////////////////////////
    // Execute stage controls
    //////////////////////////////////////////////////////////////////////
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_AND  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_XOR  = 4'd4;
    localparam logic [3:0] ALU_NOR  = 4'd5;
    localparam logic [3:0] ALU_SLT  = 4'd6;
    localparam logic [3:0] ALU_SLTU = 4'd7;
    localparam logic [3:0] ALU_LUI  = 4'd8;

    localparam logic [1:0] SH_SLL = 2'd0;
    localparam logic [1:0] SH_SRL = 2'd1;
    localparam logic [1:0] SH_SRA = 2'd2;

    localparam logic RES_ALU   = 1'b0;
    localparam logic RES_SHIFT = 1'b1;

    // Operand source in EX
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_MEM = 2'd1;
    localparam logic [1:0] FWD_WB  = 2'd2;

endpackage

/* logic/decoder.sv */
module decoder (
    input  core_pkg::word_t     instr,
    output core_pkg::reg_addr_t rs_addr,
    output core_pkg::reg_addr_t rt_addr,
    output core_pkg::reg_addr_t rd_addr,
    output logic                reg_w,
    output logic [3:0]          alu_op,
    output logic [1:0]          shift_op,
    output logic                res_sel,
    output logic                b_imm,
    output logic                shamt_var,
    output logic [4:0]          shamt,
    output core_pkg::word_t     imm_ext
);

    core_pkg::instr_u iw;
    logic             is_r;
    logic             known;
    core_pkg::word_t  imm_sext;
    core_pkg::word_t  imm_zext;

    assign iw   = instr;
    assign is_r = (iw.r.opcode == core_pkg::OP_SPECIAL);

    assign imm_sext = {{16{iw.i.imm[15]}}, iw.i.imm};
    assign imm_zext = {16'h0000, iw.i.imm};

    // Source fields share their bit positions in both layouts
    assign rs_addr = iw.r.rs;
    assign rt_addr = iw.r.rt;
    assign shamt   = iw.r.shamt;
    assign rd_addr = is_r ? iw.r.rd : iw.i.rt;

    // Unknown words and writes to $0 leave the register file alone
    assign reg_w = known && (rd_addr != '0);

    always_comb begin
        known     = 1'b1;
        alu_op    = core_pkg::ALU_ADD;
        shift_op  = core_pkg::SH_SLL;
        res_sel   = core_pkg::RES_ALU;
        b_imm     = !is_r;
        shamt_var = 1'b0;
        imm_ext   = imm_sext;
        if (is_r) begin
            case (iw.r.funct)
                core_pkg::FN_SLL:  res_sel = core_pkg::RES_SHIFT;
                core_pkg::FN_SRL: begin
                    res_sel  = core_pkg::RES_SHIFT;
                    shift_op = core_pkg::SH_SRL;
                end
                core_pkg::FN_SRA: begin
                    res_sel  = core_pkg::RES_SHIFT;
                    shift_op = core_pkg::SH_SRA;
                end
                core_pkg::FN_SLLV: begin
                    res_sel   = core_pkg::RES_SHIFT;
                    shamt_var = 1'b1;
                end
                core_pkg::FN_SRLV: begin
                    res_sel   = core_pkg::RES_SHIFT;
                    shift_op  = core_pkg::SH_SRL;
                    shamt_var = 1'b1;
                end
                core_pkg::FN_SRAV: begin
                    res_sel   = core_pkg::RES_SHIFT;
                    shift_op  = core_pkg::SH_SRA;
                    shamt_var = 1'b1;
                end
                core_pkg::FN_ADDU: alu_op = core_pkg::ALU_ADD;
                core_pkg::FN_SUBU: alu_op = core_pkg::ALU_SUB;
                core_pkg::FN_AND:  alu_op = core_pkg::ALU_AND;
                core_pkg::FN_OR:   alu_op = core_pkg::ALU_OR;
                core_pkg::FN_XOR:  alu_op = core_pkg::ALU_XOR;
                core_pkg::FN_NOR:  alu_op = core_pkg::ALU_NOR;
                core_pkg::FN_SLT:  alu_op = core_pkg::ALU_SLT;
                core_pkg::FN_SLTU: alu_op = core_pkg::ALU_SLTU;
                default:           known  = 1'b0;
            endcase
        end else begin
            // Sign extension is the default, logical ops take zero extension
            case (iw.i.opcode)
                core_pkg::OP_ADDIU: alu_op = core_pkg::ALU_ADD;
                core_pkg::OP_SLTI:  alu_op = core_pkg::ALU_SLT;
                core_pkg::OP_SLTIU: alu_op = core_pkg::ALU_SLTU;
                core_pkg::OP_ANDI: begin
                    alu_op  = core_pkg::ALU_AND;
                    imm_ext = imm_zext;
                end
                core_pkg::OP_ORI: begin
                    alu_op  = core_pkg::ALU_OR;
                    imm_ext = imm_zext;
                end
                core_pkg::OP_XORI: begin
                    alu_op  = core_pkg::ALU_XOR;
                    imm_ext = imm_zext;
                end
                core_pkg::OP_LUI: begin
                    alu_op  = core_pkg::ALU_LUI;
                    imm_ext = {iw.i.imm, 16'h0000};
                end
                default: known = 1'b0;
            endcase
        end
    end

endmodule

/* logic/gpr.sv */
module gpr (
    input  logic                ui_clk_from_ddr,
    input  logic                rst_n,
    input  core_pkg::reg_addr_t rs_addr,
    input  core_pkg::reg_addr_t rt_addr,
    output core_pkg::word_t     rs_data,
    output core_pkg::word_t     rt_data,
    input  logic                write,
    input  core_pkg::reg_addr_t rd_addr,
    input  core_pkg::word_t     rd_data
);

    core_pkg::word_t regs [32];

    // $0 is hardwired, a same-cycle write wins over the stored value
    function automatic core_pkg::word_t read_port(input core_pkg::reg_addr_t addr);
        core_pkg::word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (write && (addr == rd_addr)) begin
            val = rd_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    // Write lands on the edge that closes the WB cycle
    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

endmodule

/* logic/forward_unit.sv */
module forward_unit (
    input  core_pkg::reg_addr_t ex_rs_addr,
    input  core_pkg::reg_addr_t ex_rt_addr,
    input  logic                mem_reg_w,
    input  core_pkg::reg_addr_t mem_rd_addr,
    input  logic                wb_reg_w,
    input  core_pkg::reg_addr_t wb_rd_addr,
    output logic [1:0]          a_sel,
    output logic [1:0]          b_sel
);

    // MEM holds the younger result so it is checked first.
    // The strobes are never raised for $0, so no zero test here
    function automatic logic [1:0] pick_src(input core_pkg::reg_addr_t src);
        logic [1:0] sel;
        if (mem_reg_w && (mem_rd_addr == src)) begin
            sel = core_pkg::FWD_MEM;
        end else if (wb_reg_w && (wb_rd_addr == src)) begin
            sel = core_pkg::FWD_WB;
        end else begin
            sel = core_pkg::FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        a_sel = pick_src(ex_rs_addr);
        b_sel = pick_src(ex_rt_addr);
    end

endmodule

/* logic/execute_unit.sv */
module execute_unit (
    input  core_pkg::word_t op_a,
    input  core_pkg::word_t op_b,
    input  core_pkg::word_t mem_result,
    input  core_pkg::word_t wb_result,
    input  logic [1:0]      a_sel,
    input  logic [1:0]      b_sel,
    input  core_pkg::word_t imm_ext,
    input  logic            b_imm,
    input  logic [3:0]      alu_op,
    input  logic [1:0]      shift_op,
    input  logic            shamt_var,
    input  logic [4:0]      shamt,
    input  logic            res_sel,
    output core_pkg::word_t result
);

    core_pkg::word_t a_fwd;
    core_pkg::word_t b_fwd;
    core_pkg::word_t alu_b;
    core_pkg::word_t alu_out;
    core_pkg::word_t shift_out;
    logic [4:0]      shift_amt;

    function automatic core_pkg::word_t fwd_pick(
        input logic [1:0]      sel,
        input core_pkg::word_t reg_val
    );
        core_pkg::word_t val;
        case (sel)
            core_pkg::FWD_MEM: val = mem_result;
            core_pkg::FWD_WB:  val = wb_result;
            core_pkg::FWD_REG: val = reg_val;
            default:           val = reg_val;
        endcase
        return val;
    endfunction

    always_comb begin
        a_fwd = fwd_pick(a_sel, op_a);
        b_fwd = fwd_pick(b_sel, op_b);
    end

    assign alu_b = b_imm ? imm_ext : b_fwd;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD:  alu_out = a_fwd + alu_b;
            core_pkg::ALU_SUB:  alu_out = a_fwd - alu_b;
            core_pkg::ALU_AND:  alu_out = a_fwd & alu_b;
            core_pkg::ALU_OR:   alu_out = a_fwd | alu_b;
            core_pkg::ALU_XOR:  alu_out = a_fwd ^ alu_b;
            core_pkg::ALU_NOR:  alu_out = ~(a_fwd | alu_b);
            core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(a_fwd) < $signed(alu_b)};
            core_pkg::ALU_SLTU: alu_out = {31'b0, a_fwd < alu_b};
            // Immediate already sits in the upper half
            core_pkg::ALU_LUI:  alu_out = alu_b;
            default:            alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Barrel shifter on rt
    //////////////////////////////////////////////////////////////////////
    assign shift_amt = shamt_var ? a_fwd[4:0] : shamt;

    always_comb begin
        case (shift_op)
            core_pkg::SH_SLL: shift_out = b_fwd << shift_amt;
            core_pkg::SH_SRL: shift_out = b_fwd >> shift_amt;
            core_pkg::SH_SRA: shift_out = $signed(b_fwd) >>> shift_amt;
            default:          shift_out = b_fwd;
        endcase
    end

    assign result = (res_sel == core_pkg::RES_SHIFT) ? shift_out : alu_out;

endmodule

/* logic/pipeline.sv */
module pipeline (
    input  logic                ui_clk_from_ddr,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  core_pkg::word_t     instr,
    output logic                wb_reg_w,
    output core_pkg::reg_addr_t wb_rd_addr,
    output core_pkg::word_t     wb_data
);

    // ID stage
    logic                id_valid;
    core_pkg::word_t     id_instr;
    core_pkg::reg_addr_t id_rs_addr;
    core_pkg::reg_addr_t id_rt_addr;
    core_pkg::reg_addr_t id_rd_addr;
    logic                id_reg_w;
    logic [3:0]          id_alu_op;
    logic [1:0]          id_shift_op;
    logic                id_res_sel;
    logic                id_b_imm;
    logic                id_shamt_var;
    logic [4:0]          id_shamt;
    core_pkg::word_t     id_imm_ext;
    core_pkg::word_t     id_rs_data;
    core_pkg::word_t     id_rt_data;

    // EX stage
    logic                ex_reg_w;
    core_pkg::reg_addr_t ex_rd_addr;
    core_pkg::reg_addr_t ex_rs_addr;
    core_pkg::reg_addr_t ex_rt_addr;
    core_pkg::word_t     ex_op_a;
    core_pkg::word_t     ex_op_b;
    core_pkg::word_t     ex_imm_ext;
    logic                ex_b_imm;
    logic [3:0]          ex_alu_op;
    logic [1:0]          ex_shift_op;
    logic                ex_shamt_var;
    logic [4:0]          ex_shamt;
    logic                ex_res_sel;
    logic [1:0]          ex_a_sel;
    logic [1:0]          ex_b_sel;
    core_pkg::word_t     ex_result;

    // MEM stage
    logic                mem_reg_w;
    core_pkg::reg_addr_t mem_rd_addr;
    core_pkg::word_t     mem_result;

    //////////////////////////////////////////////////////////////////////
    // Stage strobes, a bubble travels down as a cleared strobe
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            id_valid  <= 1'b0;
            ex_reg_w  <= 1'b0;
            mem_reg_w <= 1'b0;
            wb_reg_w  <= 1'b0;
        end else begin
            id_valid  <= instr_valid;
            ex_reg_w  <= id_valid && id_reg_w;
            mem_reg_w <= ex_reg_w;
            wb_reg_w  <= mem_reg_w;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ID
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk_from_ddr) begin
        id_instr <= instr;
    end

    decoder i_decoder (
        .instr     ( id_instr     ),
        .rs_addr   ( id_rs_addr   ),
        .rt_addr   ( id_rt_addr   ),
        .rd_addr   ( id_rd_addr   ),
        .reg_w     ( id_reg_w     ),
        .alu_op    ( id_alu_op    ),
        .shift_op  ( id_shift_op  ),
        .res_sel   ( id_res_sel   ),
        .b_imm     ( id_b_imm     ),
        .shamt_var ( id_shamt_var ),
        .shamt     ( id_shamt     ),
        .imm_ext   ( id_imm_ext   )
    );

    // Written from the WB register, bypassed to ID in the same cycle
    gpr i_gpr (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .rs_addr         ( id_rs_addr      ),
        .rt_addr         ( id_rt_addr      ),
        .rs_data         ( id_rs_data      ),
        .rt_data         ( id_rt_data      ),
        .write           ( wb_reg_w        ),
        .rd_addr         ( wb_rd_addr      ),
        .rd_data         ( wb_data         )
    );

    //////////////////////////////////////////////////////////////////////
    // EX
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk_from_ddr) begin
        ex_rd_addr   <= id_rd_addr;
        ex_rs_addr   <= id_rs_addr;
        ex_rt_addr   <= id_rt_addr;
        ex_op_a      <= id_rs_data;
        ex_op_b      <= id_rt_data;
        ex_imm_ext   <= id_imm_ext;
        ex_b_imm     <= id_b_imm;
        ex_alu_op    <= id_alu_op;
        ex_shift_op  <= id_shift_op;
        ex_shamt_var <= id_shamt_var;
        ex_shamt     <= id_shamt;
        ex_res_sel   <= id_res_sel;
    end

    forward_unit i_forward (
        .ex_rs_addr  ( ex_rs_addr  ),
        .ex_rt_addr  ( ex_rt_addr  ),
        .mem_reg_w   ( mem_reg_w   ),
        .mem_rd_addr ( mem_rd_addr ),
        .wb_reg_w    ( wb_reg_w    ),
        .wb_rd_addr  ( wb_rd_addr  ),
        .a_sel       ( ex_a_sel    ),
        .b_sel       ( ex_b_sel    )
    );

    execute_unit i_execute (
        .op_a       ( ex_op_a      ),
        .op_b       ( ex_op_b      ),
        .mem_result ( mem_result   ),
        .wb_result  ( wb_data      ),
        .a_sel      ( ex_a_sel     ),
        .b_sel      ( ex_b_sel     ),
        .imm_ext    ( ex_imm_ext   ),
        .b_imm      ( ex_b_imm     ),
        .alu_op     ( ex_alu_op    ),
        .shift_op   ( ex_shift_op  ),
        .shamt_var  ( ex_shamt_var ),
        .shamt      ( ex_shamt     ),
        .res_sel    ( ex_res_sel   ),
        .result     ( ex_result    )
    );

    //////////////////////////////////////////////////////////////////////
    // MEM and WB, no memory access left so results just move along
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk_from_ddr) begin
        mem_rd_addr <= ex_rd_addr;
        mem_result  <= ex_result;
        wb_rd_addr  <= mem_rd_addr;
        wb_data     <= mem_result;
    end

endmodule

/* test/pipeline_chk.sv */
module pipeline_chk (
    input logic                ui_clk_from_ddr,
    input logic                rst_n,
    input logic                instr_valid,
    input logic                wb_reg_w,
    input core_pkg::reg_addr_t wb_rd_addr
);

    // $0 is never a write target
    wb_nonzero_dest: assert property (
        @(posedge ui_clk_from_ddr) disable iff (!rst_n)
        wb_reg_w |-> (wb_rd_addr != '0)
    ) else $error("write strobe raised for register 0");

    // Strobe into ID four edges before the write strobe is sampled
    wb_follows_issue: assert property (
        @(posedge ui_clk_from_ddr) disable iff (!rst_n)
        wb_reg_w |-> $past(instr_valid, 4)
    ) else $error("write strobe without an instruction four cycles earlier");

    wb_quiet_after_reset: assert property (
        @(posedge ui_clk_from_ddr)
        !rst_n |=> !wb_reg_w
    ) else $error("write strobe in the cycle after reset");

endmodule

/* test/tb_pipeline.sv */
module tb_pipeline;

    localparam int NUM_INSTR       = 2000;
    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 2 + 200;

    logic                ui_clk_from_ddr = 1'b0;
    logic                rst_n;
    logic                instr_valid;
    core_pkg::word_t     instr;
    logic                wb_reg_w;
    core_pkg::reg_addr_t wb_rd_addr;
    core_pkg::word_t     wb_data;

    logic [31:0]         lfsr;
    core_pkg::word_t     model_regs [32];
    int                  exp_cyc_q [$];
    core_pkg::reg_addr_t exp_addr_q [$];
    core_pkg::word_t     exp_data_q [$];
    int                  cyc = 0;
    int                  issued = 0;
    int                  checks = 0;
    int                  errors = 0;

    pipeline i_dut (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .instr_valid     ( instr_valid     ),
        .instr           ( instr           ),
        .wb_reg_w        ( wb_reg_w        ),
        .wb_rd_addr      ( wb_rd_addr      ),
        .wb_data         ( wb_data         )
    );

    bind pipeline pipeline_chk i_chk (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .instr_valid     ( instr_valid     ),
        .wb_reg_w        ( wb_reg_w        ),
        .wb_rd_addr      ( wb_rd_addr      )
    );

    always #(CLK_PERIOD / 2) ui_clk_from_ddr = ~ui_clk_from_ddr;

    always @(posedge ui_clk_from_ddr) cyc <= cyc + 1;

    //////////////////////////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hD000_0001;
        end
        return n;
    endfunction

    // One step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Mostly the low eight registers so hazards come up often
    function automatic core_pkg::reg_addr_t pick_reg();
        logic [31:0] bits;
        if (take_bits(2) == 32'd3) begin
            bits = take_bits(5);
        end else begin
            bits = take_bits(3);
        end
        return bits[4:0];
    endfunction

    function automatic core_pkg::word_t encode(
        input int                  sel,
        input core_pkg::reg_addr_t rs,
        input core_pkg::reg_addr_t rt,
        input core_pkg::reg_addr_t rd,
        input logic [4:0]          sh,
        input logic [15:0]         imm
    );
        logic [5:0] code;
        case (sel)
            0:       code = core_pkg::FN_ADDU;
            1:       code = core_pkg::FN_SUBU;
            2:       code = core_pkg::FN_AND;
            3:       code = core_pkg::FN_OR;
            4:       code = core_pkg::FN_XOR;
            5:       code = core_pkg::FN_NOR;
            6:       code = core_pkg::FN_SLT;
            7:       code = core_pkg::FN_SLTU;
            8:       code = core_pkg::FN_SLL;
            9:       code = core_pkg::FN_SRL;
            10:      code = core_pkg::FN_SRA;
            11:      code = core_pkg::FN_SLLV;
            12:      code = core_pkg::FN_SRLV;
            13:      code = core_pkg::FN_SRAV;
            14:      code = core_pkg::OP_ADDIU;
            15:      code = core_pkg::OP_ANDI;
            16:      code = core_pkg::OP_ORI;
            17:      code = core_pkg::OP_XORI;
            18:      code = core_pkg::OP_SLTI;
            19:      code = core_pkg::OP_SLTIU;
            default: code = core_pkg::OP_LUI;
        endcase
        if (sel < 14) begin
            return {core_pkg::OP_SPECIAL, rs, rt, rd, sh, code};
        end
        return {code, rs, rt, imm};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Architectural model updated in program order at issue
    //////////////////////////////////////////////////////////////////////
    task automatic model_issue(input core_pkg::word_t w);
        logic [5:0]          op;
        logic [5:0]          fn;
        logic [4:0]          sh;
        core_pkg::reg_addr_t dest;
        core_pkg::word_t     a;
        core_pkg::word_t     b;
        core_pkg::word_t     sx;
        core_pkg::word_t     zx;
        core_pkg::word_t     val;
        logic                known;
        op    = w[31:26];
        fn    = w[5:0];
        sh    = w[10:6];
        a     = model_regs[w[25:21]];
        b     = model_regs[w[20:16]];
        sx    = {{16{w[15]}}, w[15:0]};
        zx    = {16'h0000, w[15:0]};
        known = 1'b1;
        val   = '0;
        if (op == core_pkg::OP_SPECIAL) begin
            dest = w[15:11];
            case (fn)
                core_pkg::FN_SLL:  val = b << sh;
                core_pkg::FN_SRL:  val = b >> sh;
                core_pkg::FN_SRA:  val = $signed(b) >>> sh;
                core_pkg::FN_SLLV: val = b << a[4:0];
                core_pkg::FN_SRLV: val = b >> a[4:0];
                core_pkg::FN_SRAV: val = $signed(b) >>> a[4:0];
                core_pkg::FN_ADDU: val = a + b;
                core_pkg::FN_SUBU: val = a - b;
                core_pkg::FN_AND:  val = a & b;
                core_pkg::FN_OR:   val = a | b;
                core_pkg::FN_XOR:  val = a ^ b;
                core_pkg::FN_NOR:  val = ~(a | b);
                core_pkg::FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                core_pkg::FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
                default:           known = 1'b0;
            endcase
        end else begin
            dest = w[20:16];
            case (op)
                core_pkg::OP_ADDIU: val = a + sx;
                core_pkg::OP_SLTI:  val = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                core_pkg::OP_SLTIU: val = (a < sx) ? 32'd1 : 32'd0;
                core_pkg::OP_ANDI:  val = a & zx;
                core_pkg::OP_ORI:   val = a | zx;
                core_pkg::OP_XORI:  val = a ^ zx;
                core_pkg::OP_LUI:   val = {w[15:0], 16'h0000};
                default:            known = 1'b0;
            endcase
        end
        if (known && (dest != '0)) begin
            model_regs[dest] = val;
            exp_cyc_q.push_back(cyc + 4);
            exp_addr_q.push_back(dest);
            exp_data_q.push_back(val);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Write-back check once per cycle at the falling edge
    //////////////////////////////////////////////////////////////////////
    task automatic check_wb();
        if ((exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cyc)) begin
            checks++;
            if (wb_reg_w !== 1'b1) begin
                errors++;
                $display("[ERROR] t=%0t wb_reg_w expected 1 actual %b", $time, wb_reg_w);
            end else begin
                if (wb_rd_addr !== exp_addr_q[0]) begin
                    errors++;
                    $display("[ERROR] t=%0t wb_rd_addr expected %0d actual %0d",
                             $time, exp_addr_q[0], wb_rd_addr);
                end
                if (wb_data !== exp_data_q[0]) begin
                    errors++;
                    $display("[ERROR] t=%0t wb_data expected %h actual %h",
                             $time, exp_data_q[0], wb_data);
                end
            end
            void'(exp_cyc_q.pop_front());
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
        end else if (wb_reg_w !== 1'b0) begin
            errors++;
            $display("[ERROR] t=%0t wb_reg_w expected 0 actual %b", $time, wb_reg_w);
        end
    endtask

    task automatic next_cycle();
        @(negedge ui_clk_from_ddr);
        check_wb();
    endtask

    task automatic drive_slot(input logic valid, input core_pkg::word_t word);
        next_cycle();
        instr_valid = valid;
        instr       = word;
        if (valid) begin
            model_issue(word);
        end
    endtask

    // In-flight writes are lost and the model forgets them too
    task automatic apply_reset();
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        exp_cyc_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        repeat (4) next_cycle();
        rst_n = 1'b1;
    endtask

    // or rN, $0, rN copies every register onto the write-back port
    task automatic read_back_all();
        core_pkg::reg_addr_t ra;
        for (int r = 1; r < 32; r++) begin
            ra = r[4:0];
            drive_slot(1'b1, {core_pkg::OP_SPECIAL, 5'd0, ra, ra, 5'd0, core_pkg::FN_OR});
        end
    endtask

    task automatic issue_random();
        int          sel;
        logic [31:0] bits;
        logic [4:0]  sh;
        logic [15:0] imm;
        core_pkg::reg_addr_t rs;
        core_pkg::reg_addr_t rt;
        core_pkg::reg_addr_t rd;
        if (take_bits(3) == 32'd0) begin
            drive_slot(1'b0, take_bits(32));
        end else begin
            bits = take_bits(5);
            sel  = int'(bits % 32'd21);
            rs   = pick_reg();
            rt   = pick_reg();
            rd   = pick_reg();
            bits = take_bits(5);
            sh   = bits[4:0];
            bits = take_bits(16);
            imm  = bits[15:0];
            drive_slot(1'b1, encode(sel, rs, rt, rd, sh, imm));
            issued++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic mid_reset_done;
        mid_reset_done = 1'b0;
        lfsr           = 32'd79;
        instr          = '0;
        apply_reset();
        while (issued < NUM_INSTR) begin
            if ((issued == NUM_INSTR / 2) && !mid_reset_done) begin
                next_cycle();
                apply_reset();
                read_back_all();
                mid_reset_done = 1'b1;
            end
            issue_random();
        end
        read_back_all();
        repeat (5) drive_slot(1'b0, '0);
        $display("Writes checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the instruction stream finished");
        $display("Test FAILED");
        $finish;
    end

endmodule

/* build.f */
logic/core_pkg.sv
logic/decoder.sv
logic/gpr.sv
logic/forward_unit.sv
logic/execute_unit.sv
logic/pipeline.sv
test/pipeline_chk.sv
test/tb_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pipeline
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
